// ==== diff_engine.sv ====
// Difference engine sequencer on RAM port B with sticky borrow flag
module diff_engine (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  logic [mem_pkg::ADDR_WIDTH-1:0] src_a,
    input  logic [mem_pkg::ADDR_WIDTH-1:0] src_b,
    input  logic [mem_pkg::ADDR_WIDTH-1:0] dst,
    output logic                           busy,
    output logic                           borrow,
    // RAM port B
    output logic [mem_pkg::ADDR_WIDTH-1:0] ram_addr,
    output logic                           ram_we,
    output logic [mem_pkg::DATA_WIDTH-1:0] ram_wdata,
    input  logic [mem_pkg::DATA_WIDTH-1:0] ram_rdata
);
    import mem_pkg::*;

    // Four active states, one per busy cycle
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_A,
        ST_RD_B,
        ST_CALC,
        ST_WRITE
    } state_t;

    state_t state;

    logic [DATA_WIDTH-1:0] a_q;
    logic [DATA_WIDTH-1:0] diff_q;
    logic                  borrow_q;
    logic [DATA_WIDTH-1:0] sub_diff;
    logic                  sub_borrow;

    // Operand b comes straight from the RAM read register
    lookahead_subtractor #(
        .WIDTH (DATA_WIDTH)
    ) u_sub (
        .a      (a_q),
        .b      (ram_rdata),
        .diff   (sub_diff),
        .borrow (sub_borrow)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  if (start) state <= ST_RD_A;
                ST_RD_A:  state <= ST_RD_B;
                ST_RD_B:  state <= ST_CALC;
                ST_CALC:  state <= ST_WRITE;
                ST_WRITE: state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // Operand and result registers
    always_ff @(posedge clk) begin
        if (state == ST_RD_B) begin
            a_q <= ram_rdata;
        end
        if (state == ST_CALC) begin
            diff_q   <= sub_diff;
            borrow_q <= sub_borrow;
        end
    end

    // Borrow holds its value until the next write-back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            borrow <= 1'b0;
        end else if (state == ST_WRITE) begin
            borrow <= borrow_q;
        end
    end

    always_comb begin
        case (state)
            ST_RD_B:  ram_addr = src_b;
            ST_WRITE: ram_addr = dst;
            default:  ram_addr = src_a;
        endcase
    end

    assign ram_we = (state == ST_WRITE);
    assign ram_wdata = diff_q;
    assign busy = (state != ST_IDLE);

    // The bus slave holds off CTRL writes until the engine is idle
    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> !busy
    ) else $error("start arrived while the engine was busy");

endmodule

// ==== diff_mem_top.sv ====
// Top level joining the Wishbone slave, dual-port RAM and difference engine
module diff_mem_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [wb_pkg::WB_ADR_WIDTH-1:0] wb_adr,
    input  logic [mem_pkg::DATA_WIDTH-1:0]  wb_dat_w,
    output logic [mem_pkg::DATA_WIDTH-1:0]  wb_dat_r,
    output logic                            wb_ack
);
    import mem_pkg::*;

    // Port A, bus side
    logic [ADDR_WIDTH-1:0] ram_a_addr;
    logic                  ram_a_we;
    logic [DATA_WIDTH-1:0] ram_a_wdata;
    logic [DATA_WIDTH-1:0] ram_a_rdata;

    // Port B, engine side
    logic [ADDR_WIDTH-1:0] ram_b_addr;
    logic                  ram_b_we;
    logic [DATA_WIDTH-1:0] ram_b_wdata;
    logic [DATA_WIDTH-1:0] ram_b_rdata;

    // Engine control
    logic                  start;
    logic [ADDR_WIDTH-1:0] src_a;
    logic [ADDR_WIDTH-1:0] src_b;
    logic [ADDR_WIDTH-1:0] dst;
    logic                  busy;
    logic                  borrow;

    wb_regs u_wb_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .ram_addr  (ram_a_addr),
        .ram_we    (ram_a_we),
        .ram_wdata (ram_a_wdata),
        .ram_rdata (ram_a_rdata),
        .start     (start),
        .src_a     (src_a),
        .src_b     (src_b),
        .dst       (dst),
        .busy      (busy),
        .borrow    (borrow)
    );

    dual_port_ram #(
        .DEPTH (RAM_DEPTH)
    ) u_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .a_addr  (ram_a_addr),
        .a_we    (ram_a_we),
        .a_wdata (ram_a_wdata),
        .a_rdata (ram_a_rdata),
        .b_addr  (ram_b_addr),
        .b_we    (ram_b_we),
        .b_wdata (ram_b_wdata),
        .b_rdata (ram_b_rdata)
    );

    diff_engine u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .src_a     (src_a),
        .src_b     (src_b),
        .dst       (dst),
        .busy      (busy),
        .borrow    (borrow),
        .ram_addr  (ram_b_addr),
        .ram_we    (ram_b_we),
        .ram_wdata (ram_b_wdata),
        .ram_rdata (ram_b_rdata)
    );

endmodule

// ==== dual_port_ram.sv ====
// Dual-port synchronous RAM with a registered read-first output on each port
module dual_port_ram #(
    parameter int DEPTH = mem_pkg::RAM_DEPTH
) (
    input  logic                           clk,
    input  logic                           rst_n,
    // Port A, bus side
    input  logic [mem_pkg::ADDR_WIDTH-1:0] a_addr,
    input  logic                           a_we,
    input  logic [mem_pkg::DATA_WIDTH-1:0] a_wdata,
    output logic [mem_pkg::DATA_WIDTH-1:0] a_rdata,
    // Port B, engine side
    input  logic [mem_pkg::ADDR_WIDTH-1:0] b_addr,
    input  logic                           b_we,
    input  logic [mem_pkg::DATA_WIDTH-1:0] b_wdata,
    output logic [mem_pkg::DATA_WIDTH-1:0] b_rdata
);
    import mem_pkg::*;

    logic [DATA_WIDTH-1:0] mem [0:DEPTH-1];

    // Port B is written last so it wins a same-address collision
    always_ff @(posedge clk) begin
        if (a_we) begin
            mem[a_addr] <= a_wdata;
        end
        if (b_we) begin
            mem[b_addr] <= b_wdata;
        end
    end

    // Read-first, old contents come out during a write
    always_ff @(posedge clk) begin
        a_rdata <= mem[a_addr];
        b_rdata <= mem[b_addr];
    end

    // The bus stall keeps port A off the RAM while the engine writes
    a_no_write_collision: assert property (
        @(posedge clk) disable iff (!rst_n)
        (a_we && b_we) |-> (a_addr != b_addr)
    ) else $error("port A and port B wrote the same word in one cycle");

endmodule

// ==== flist.f ====
mem_pkg.sv
wb_pkg.sv
dual_port_ram.sv
lookahead_subtractor.sv
diff_engine.sv
wb_regs.sv
diff_mem_top.sv
tb_diff_mem.sv

// ==== lookahead_subtractor.sv ====
// Combinational borrow-lookahead subtractor, diff = a - b with borrow out
module lookahead_subtractor #(
    parameter int WIDTH = mem_pkg::DATA_WIDTH
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] diff,
    output logic             borrow
);
    logic [WIDTH-1:0] b_inv;
    logic [WIDTH-1:0] g;
    logic [WIDTH-1:0] p;
    logic [WIDTH:0]   carry;

    // a - b computed as a + ~b + 1
    assign b_inv = ~b;
    assign g = a & b_inv;
    assign p = a ^ b_inv;

    // Each carry expanded as g[i] | p[i]g[i-1] | ... | p[i..0]c0
    always_comb begin
        logic term;
        logic chain;
        carry[0] = 1'b1;
        for (int i = 0; i < WIDTH; i++) begin
            term = 1'b0;
            chain = 1'b1;
            for (int j = i; j >= 0; j--) begin
                term = term | (chain & g[j]);
                chain = chain & p[j];
            end
            carry[i+1] = term | (chain & carry[0]);
        end
    end

    assign diff = p ^ carry[WIDTH-1:0];

    // No carry out means a was below b
    assign borrow = ~carry[WIDTH];

endmodule

// ==== mem_pkg.sv ====
// Memory geometry and data word constants
package mem_pkg;

    // Width of one RAM word and of each operand
    localparam int DATA_WIDTH = 8;

    // Word address into the RAM
    localparam int ADDR_WIDTH = 6;

    // Number of words held in the RAM
    localparam int RAM_DEPTH = 1 << ADDR_WIDTH;

endpackage

// ==== tb_diff_mem.sv ====
// Testbench for diff_mem_top with bus tasks, reference memory, assertions and timeout
module tb_diff_mem;
    timeunit 1ns;
    timeprecision 100ps;
    import mem_pkg::*;
    import wb_pkg::*;

    localparam int MAX_CYCLES = 3000;
    localparam logic [WB_ADR_WIDTH-1:0] REG_BASE = {1'b1, {ADDR_WIDTH{1'b0}}};

    logic                    clk;
    logic                    rst_n;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [WB_ADR_WIDTH-1:0] wb_adr;
    logic [DATA_WIDTH-1:0]   wb_dat_w;
    logic [DATA_WIDTH-1:0]   wb_dat_r;
    logic                    wb_ack;
    logic                    watch_stall;
    int                      cycles = 0;

    // Mirror of every RAM write, engine results included
    logic [DATA_WIDTH-1:0] ref_mem [0:RAM_DEPTH-1];

    diff_mem_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(input string what);
        $display("mismatch at %0t: %s", $time, what);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            report_failure("timeout: the run went past its cycle limit");
        end
    end

    // Sampled mid-cycle so the first reset edge has settled
    ack_in_reset: assert property (@(negedge clk) !rst_n |-> !wb_ack)
        else report_mismatch("wb_ack high during reset");
    ack_needs_request: assert property (
        @(posedge clk) disable iff (!rst_n) wb_ack |-> (wb_cyc && wb_stb)
    ) else report_mismatch("wb_ack high without wb_cyc and wb_stb");
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
        else report_mismatch("wb_ack high for two cycles in a row");
    // No bus ack at all while the engine runs during the stall test
    no_ack_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) (watch_stall && DUT.busy) |-> !wb_ack
    ) else report_mismatch("access acked while the engine was busy");

    function automatic logic [WB_ADR_WIDTH-1:0] reg_adr(input logic [REG_OFS_WIDTH-1:0] ofs);
        return REG_BASE | ofs;
    endfunction

    // One request held until ack, data captured mid-cycle
    task automatic bus_access(input logic we, input logic [WB_ADR_WIDTH-1:0] adr,
                              input logic [DATA_WIDTH-1:0] wdata,
                              output logic [DATA_WIDTH-1:0] rdata);
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdata;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        rdata = wb_dat_r;
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic bus_write(input logic [WB_ADR_WIDTH-1:0] adr, input logic [DATA_WIDTH-1:0] data);
        logic [DATA_WIDTH-1:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input logic [WB_ADR_WIDTH-1:0] adr, output logic [DATA_WIDTH-1:0] data);
        bus_access(1'b0, adr, '0, data);
    endtask

    task automatic load_operands(input logic [ADDR_WIDTH-1:0] sa, input logic [ADDR_WIDTH-1:0] sb,
                                 input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
        bus_write({1'b0, sa}, a);
        ref_mem[sa] = a;
        bus_write({1'b0, sb}, b);
        ref_mem[sb] = b;
    endtask

    // Programs one operation, optionally reads dst while busy, then checks
    task automatic run_difference(input logic [ADDR_WIDTH-1:0] sa, input logic [ADDR_WIDTH-1:0] sb,
                                  input logic [ADDR_WIDTH-1:0] d, input bit stalled);
        logic [DATA_WIDTH-1:0] exp_diff;
        logic                  exp_borrow;
        logic [DATA_WIDTH-1:0] status;
        logic [DATA_WIDTH-1:0] rdata;
        // a minus b modulo 256, borrow when a is below b
        exp_diff = ref_mem[sa] - ref_mem[sb];
        exp_borrow = ref_mem[sa] < ref_mem[sb];
        bus_write(reg_adr(REG_SRC_A), sa);
        bus_write(reg_adr(REG_SRC_B), sb);
        bus_write(reg_adr(REG_DST), d);
        bus_write(reg_adr(REG_CTRL), 8'h01);
        ref_mem[d] = exp_diff;
        if (stalled) begin
            watch_stall = 1'b1;
            bus_read({1'b0, d}, rdata);
            watch_stall = 1'b0;
            assert (rdata == exp_diff)
                else report_mismatch($sformatf("stalled read %0h, expected %0h", rdata, exp_diff));
        end
        status = 8'h01;
        while (status[STATUS_BUSY_BIT]) bus_read(reg_adr(REG_STATUS), status);
        assert (status[STATUS_BORROW_BIT] == exp_borrow)
            else report_mismatch($sformatf("borrow %0b, expected %0b",
                                           status[STATUS_BORROW_BIT], exp_borrow));
        bus_read({1'b0, d}, rdata);
        assert (rdata == exp_diff)
            else report_mismatch($sformatf("dst %0d read %0h, expected %0h", d, rdata, exp_diff));
    endtask

    initial begin
        logic [DATA_WIDTH-1:0] rdata;
        logic [ADDR_WIDTH-1:0] addrs [$];
        logic [ADDR_WIDTH-1:0] adr;
        void'($urandom(10584));
        watch_stall = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (wb_ack == 1'b0) else report_mismatch("wb_ack high right after reset");
        bus_read(reg_adr(REG_STATUS), rdata);
        assert (rdata == 8'h00) else report_mismatch($sformatf("STATUS after reset %0h", rdata));

        // RAM window through port A
        for (int i = 0; i < 40; i++) begin
            adr = $urandom() % RAM_DEPTH;
            addrs.push_back(adr);
            ref_mem[adr] = $urandom();
            bus_write({1'b0, adr}, ref_mem[adr]);
        end
        foreach (addrs[i]) begin
            bus_read({1'b0, addrs[i]}, rdata);
            assert (rdata == ref_mem[addrs[i]])
                else report_mismatch($sformatf("ram word %0d read %0h, expected %0h",
                                               addrs[i], rdata, ref_mem[addrs[i]]));
        end

        load_operands(6'd10, 6'd11, 8'd200, 8'd55);
        run_difference(6'd10, 6'd11, 6'd12, 1'b0);
        load_operands(6'd20, 6'd21, 8'd17, 8'd230);
        run_difference(6'd20, 6'd21, 6'd22, 1'b0);
        // Source and destination on the same word
        load_operands(6'd30, 6'd31, 8'd90, 8'd91);
        run_difference(6'd30, 6'd31, 6'd30, 1'b0);
        for (int i = 0; i < 8; i++) begin
            adr = $urandom() % RAM_DEPTH;
            load_operands(adr, adr ^ 6'd5, $urandom(), $urandom());
            run_difference(adr, adr ^ 6'd5, $urandom() % RAM_DEPTH, 1'b0);
        end
        load_operands(6'd40, 6'd41, 8'd3, 8'd129);
        run_difference(6'd40, 6'd41, 6'd42, 1'b1);

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== wb_pkg.sv ====
// Wishbone address width, register offsets and status bit positions
package wb_pkg;

    // Word address plus one region bit, top bit set selects the registers
    localparam int WB_ADR_WIDTH = mem_pkg::ADDR_WIDTH + 1;

    // Low address bits that pick a register inside the register region
    localparam int REG_OFS_WIDTH = 3;

    // Register map
    localparam logic [REG_OFS_WIDTH-1:0] REG_CTRL = 3'd0;
    localparam logic [REG_OFS_WIDTH-1:0] REG_SRC_A = 3'd1;
    localparam logic [REG_OFS_WIDTH-1:0] REG_SRC_B = 3'd2;
    localparam logic [REG_OFS_WIDTH-1:0] REG_DST = 3'd3;
    localparam logic [REG_OFS_WIDTH-1:0] REG_STATUS = 3'd4;

    // CTRL write bit that launches an operation
    localparam int CTRL_START_BIT = 0;

    // STATUS bit positions
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_BORROW_BIT = 1;

endpackage

// ==== wb_regs.sv ====
// Wishbone classic slave with RAM window, control registers and busy stall
module wb_regs (
    input  logic                             clk,
    input  logic                             rst_n,
    // Wishbone slave
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [wb_pkg::WB_ADR_WIDTH-1:0]  wb_adr,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   wb_dat_w,
    output logic [mem_pkg::DATA_WIDTH-1:0]   wb_dat_r,
    output logic                             wb_ack,
    // RAM port A
    output logic [mem_pkg::ADDR_WIDTH-1:0]   ram_addr,
    output logic                             ram_we,
    output logic [mem_pkg::DATA_WIDTH-1:0]   ram_wdata,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   ram_rdata,
    // Engine control
    output logic                             start,
    output logic [mem_pkg::ADDR_WIDTH-1:0]   src_a,
    output logic [mem_pkg::ADDR_WIDTH-1:0]   src_b,
    output logic [mem_pkg::ADDR_WIDTH-1:0]   dst,
    input  logic                             busy,
    input  logic                             borrow
);
    import mem_pkg::*;
    import wb_pkg::*;

    logic                     reg_sel;
    logic [REG_OFS_WIDTH-1:0] reg_ofs;
    logic                     status_rd;
    logic                     stall;
    logic                     accept;
    logic                     reg_wr;
    logic [DATA_WIDTH-1:0]    reg_rdata;

    // Top address bit selects the register region
    assign reg_sel = wb_adr[WB_ADR_WIDTH-1];
    assign reg_ofs = wb_adr[REG_OFS_WIDTH-1:0];

    // Only a STATUS read may pass while the engine runs
    assign status_rd = reg_sel && !wb_we && (reg_ofs == REG_STATUS);
    assign stall = busy && !status_rd;

    // Request taken this cycle, acked on the next one
    assign accept = wb_cyc && wb_stb && !wb_ack && !stall;
    assign reg_wr = accept && wb_we && reg_sel;

    // RAM window on port A, address presented in the request cycle
    assign ram_addr = wb_adr[ADDR_WIDTH-1:0];
    assign ram_we = accept && wb_we && !reg_sel;
    assign ram_wdata = wb_dat_w;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            start  <= 1'b0;
        end else begin
            wb_ack <= accept;
            // Start pulse lines up with the CTRL write ack
            start  <= reg_wr && (reg_ofs == REG_CTRL) && wb_dat_w[CTRL_START_BIT];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_a <= '0;
            src_b <= '0;
            dst   <= '0;
        end else if (reg_wr) begin
            case (reg_ofs)
                REG_SRC_A: src_a <= wb_dat_w[ADDR_WIDTH-1:0];
                REG_SRC_B: src_b <= wb_dat_w[ADDR_WIDTH-1:0];
                REG_DST:   dst   <= wb_dat_w[ADDR_WIDTH-1:0];
                default:   ;
            endcase
        end
    end

    // Register read mux, CTRL reads back as zero
    always_comb begin
        reg_rdata = '0;
        case (reg_ofs)
            REG_SRC_A: reg_rdata[ADDR_WIDTH-1:0] = src_a;
            REG_SRC_B: reg_rdata[ADDR_WIDTH-1:0] = src_b;
            REG_DST:   reg_rdata[ADDR_WIDTH-1:0] = dst;
            REG_STATUS: begin
                reg_rdata[STATUS_BUSY_BIT]   = busy;
                reg_rdata[STATUS_BORROW_BIT] = borrow;
            end
            default: ;
        endcase
    end

    // Address is held by the master, so the mux is stable at ack
    assign wb_dat_r = reg_sel ? reg_rdata : ram_rdata;

    // The master must keep the request up until it sees ack
    a_ack_with_request: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb)
    ) else $error("ack without cyc and stb");

endmodule
